// File: controlPipe.f
hw/ctrlPkg.sv
hw/ctrlBundleIf.sv
hw/aluOpDecoder.sv
hw/systemDecoder.sv
hw/controlDecoder.sv
hw/ctrlSkidBuffer.sv
hw/controlPipe.sv
tb/controlPipeTb.sv

// File: hw/aluOpDecoder.sv
`timescale 1ns/10ps

module aluOpDecoder (
    input  logic [2:0]                   funct3,
    input  logic [6:0]                   funct7,
    input  logic                         isRegOp,
    output logic [ctrlPkg::aluOpWidth-1:0] aluControl,
    output logic                         aluInvalid
);
    import ctrlPkg::*;

    logic altForm;

    assign altForm = (funct7 == funct7Alt);

    always_comb begin
        aluControl = aluNull;
        aluInvalid = 1'b0;
        if (isRegOp && funct7 == funct7MulDiv) begin
            case (funct3)
                funct3Mul:    aluControl = aluMul;
                funct3Mulh:   aluControl = aluMulh;
                funct3Mulhsu: aluControl = aluMulhsu;
                funct3Mulhu:  aluControl = aluMulhu;
                funct3Div:    aluControl = aluDiv;
                funct3Divu:   aluControl = aluDivu;
                funct3Rem:    aluControl = aluRem;
                default:      aluControl = aluRemu;
            endcase
        end else if (isRegOp && funct7 != funct7Base && !altForm) begin
            aluInvalid = 1'b1; // Unknown funct7
        end else begin
            case (funct3)
                funct3Add:  aluControl = (isRegOp && altForm) ? aluSub : aluAdd; // ADDI has no SUB
                funct3Sll:  aluControl = aluSll;
                funct3Slt:  aluControl = aluSlt;
                funct3Sltu: aluControl = aluSltu;
                funct3Xor:  aluControl = aluXor;
                funct3Srl:  aluControl = altForm ? aluSra : aluSrl;
                funct3Or:   aluControl = aluOr;
                default:    aluControl = aluAnd;
            endcase
        end
    end

endmodule

// File: hw/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
    input  ctrlPkg::instrWord instr,
    ctrlBundleIf.source       bundle
);
    import ctrlPkg::*;

    ctrlBundleIf sysBundle ();

    logic [aluOpWidth-1:0] aluOp;
    logic                  aluInvalid;
    logic                  isRegOp;
    logic                  knownOpc;
    logic                  badInstr;

    assign isRegOp  = (instr.r.opcode == opcOp);
    assign knownOpc = instr.r.opcode inside {opcSystem, opcLoad, opcOpImm, opcAuipc, opcStore,
                                             opcOp, opcLui, opcBranch, opcJalr, opcJal};
    assign badInstr = !knownOpc || aluInvalid;

    aluOpDecoder iAluOpDecoder (
        .funct3     (instr.r.funct3),
        .funct7     (instr.r.funct7),
        .isRegOp    (isRegOp),
        .aluControl (aluOp),
        .aluInvalid (aluInvalid)
    );

    systemDecoder iSystemDecoder (
        .funct3  (instr.i.funct3),
        .funct12 (instr.i.funct12),
        .bundle  (sysBundle.source)
    );

    always_comb begin
        bundle.ecall      = 1'b0;
        bundle.ebreak     = 1'b0;
        bundle.invInstr   = badInstr; // Everything else stays at zero
        bundle.origA      = origAReg;
        bundle.origB      = origBReg;
        bundle.regWrite   = 1'b0;
        bundle.csRegWrite = 1'b0;
        bundle.memWrite   = 1'b0;
        bundle.memRead    = 1'b0;
        bundle.mem2Reg    = wbAlu;
        bundle.origPc     = pcNext;
        bundle.aluControl = aluNull;
        bundle.instrType  = '0;

        if (!badInstr) begin
            case (instr.r.opcode)
                opcLoad: begin
                    bundle.origB               = origBImm;
                    bundle.regWrite            = 1'b1;
                    bundle.memRead             = 1'b1;
                    bundle.mem2Reg             = wbMem;
                    bundle.aluControl          = aluAdd;
                    bundle.instrType[typeLoad] = 1'b1;
                end
                opcStore: begin
                    bundle.origB                = origBImm;
                    bundle.memWrite             = 1'b1;
                    bundle.aluControl           = aluAdd;
                    bundle.instrType[typeStore] = 1'b1;
                end
                opcBranch: begin
                    bundle.aluControl            = aluAdd;
                    bundle.origPc                = pcBranch;
                    bundle.instrType[typeBranch] = 1'b1;
                end
                opcJal, opcJalr: begin
                    bundle.regWrite = 1'b1;
                    bundle.mem2Reg  = wbPcPlus4; // Link address
                    bundle.origPc   = (instr.r.opcode == opcJal) ? pcJal : pcJalr;
                    bundle.instrType[typeJal]  = (instr.r.opcode == opcJal);
                    bundle.instrType[typeJalr] = (instr.r.opcode == opcJalr);
                end
                opcAuipc, opcLui, opcOpImm: begin
                    bundle.origA   = (instr.r.opcode == opcAuipc) ? origAPc : origAReg;
                    bundle.origB   = origBImm;
                    bundle.regWrite = 1'b1;
                    bundle.instrType[typeI] = 1'b1;
                    case (instr.r.opcode)
                        opcAuipc: bundle.aluControl = aluAdd;
                        opcLui:   bundle.aluControl = aluLui;
                        default:  bundle.aluControl = aluOp;
                    endcase
                end
                opcOp: begin
                    bundle.regWrite              = 1'b1;
                    bundle.aluControl            = aluOp;
                    bundle.instrType[typeR]      = 1'b1;
                    bundle.instrType[typeDivRem] = (instr.r.funct7 == funct7MulDiv);
                end
                default: begin // SYSTEM
                    bundle.ecall      = sysBundle.ecall;
                    bundle.ebreak     = sysBundle.ebreak;
                    bundle.invInstr   = sysBundle.invInstr;
                    bundle.origA      = sysBundle.origA;
                    bundle.origB      = sysBundle.origB;
                    bundle.regWrite   = sysBundle.regWrite;
                    bundle.csRegWrite = sysBundle.csRegWrite;
                    bundle.memWrite   = sysBundle.memWrite;
                    bundle.memRead    = sysBundle.memRead;
                    bundle.mem2Reg    = sysBundle.mem2Reg;
                    bundle.origPc     = sysBundle.origPc;
                    bundle.aluControl = sysBundle.aluControl;
                    bundle.instrType  = sysBundle.instrType;
                end
            endcase
        end
    end

endmodule

// File: hw/controlPipe.sv
`timescale 1ns/10ps

module controlPipe (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [ctrlPkg::xlen-1:0]           instr,
    input  logic                               instrValid,
    output logic                               instrReady,
    output logic                               ctrlValid,
    input  logic                               ctrlReady,
    output logic                               ecall,
    output logic                               ebreak,
    output logic                               invInstr,
    output logic [ctrlPkg::origWidth-1:0]      origA,
    output logic [ctrlPkg::origWidth-1:0]      origB,
    output logic                               regWrite,
    output logic                               csRegWrite,
    output logic                               memWrite,
    output logic                               memRead,
    output logic [ctrlPkg::wbWidth-1:0]        mem2Reg,
    output logic [ctrlPkg::pcWidth-1:0]        origPc,
    output logic [ctrlPkg::aluOpWidth-1:0]     aluControl,
    output logic [ctrlPkg::instrTypeWidth-1:0] instrType
);

    ctrlBundleIf decBundle (); // Decoder output, same cycle

    controlDecoder iControlDecoder (
        .instr  (instr),
        .bundle (decBundle.source)
    );

    ctrlSkidBuffer iCtrlSkidBuffer (
        .clk,
        .arstN,
        .inValid  (instrValid),
        .inReady  (instrReady),
        .bundleIn (decBundle.sink),
        .outValid (ctrlValid),
        .outReady (ctrlReady),
        .ecall,
        .ebreak,
        .invInstr,
        .origA,
        .origB,
        .regWrite,
        .csRegWrite,
        .memWrite,
        .memRead,
        .mem2Reg,
        .origPc,
        .aluControl,
        .instrType
    );

endmodule

// File: hw/ctrlBundleIf.sv
`timescale 1ns/10ps

interface ctrlBundleIf;
    import ctrlPkg::*;

    logic                      ecall;
    logic                      ebreak;
    logic                      invInstr;
    logic [origWidth-1:0]      origA;
    logic [origWidth-1:0]      origB;
    logic                      regWrite;
    logic                      csRegWrite;
    logic                      memWrite;
    logic                      memRead;
    logic [wbWidth-1:0]        mem2Reg;
    logic [pcWidth-1:0]        origPc;
    logic [aluOpWidth-1:0]     aluControl;
    logic [instrTypeWidth-1:0] instrType;

    modport source (
        output ecall, ebreak, invInstr, origA, origB, regWrite, csRegWrite,
               memWrite, memRead, mem2Reg, origPc, aluControl, instrType
    );

    modport sink (
        input ecall, ebreak, invInstr, origA, origB, regWrite, csRegWrite,
              memWrite, memRead, mem2Reg, origPc, aluControl, instrType
    );

endinterface

// File: hw/ctrlPkg.sv
package ctrlPkg;

    localparam int xlen           = 32;
    localparam int aluOpWidth     = 5;
    localparam int instrTypeWidth = 9;
    localparam int origWidth      = 2;
    localparam int wbWidth        = 3;
    localparam int pcWidth        = 3;
    localparam int bundleWidth    = 3 + 2 * origWidth + 4 + wbWidth + pcWidth + aluOpWidth
                                    + instrTypeWidth;

    localparam logic [6:0] opcSystem = 7'b1110011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcJal    = 7'b1101111;

    localparam logic [2:0] funct3Add  = 3'd0; // SUB shares it
    localparam logic [2:0] funct3Sll  = 3'd1;
    localparam logic [2:0] funct3Slt  = 3'd2;
    localparam logic [2:0] funct3Sltu = 3'd3;
    localparam logic [2:0] funct3Xor  = 3'd4;
    localparam logic [2:0] funct3Srl  = 3'd5; // SRA shares it
    localparam logic [2:0] funct3Or   = 3'd6;
    localparam logic [2:0] funct3And  = 3'd7;

    localparam logic [2:0] funct3Mul    = 3'd0;
    localparam logic [2:0] funct3Mulh   = 3'd1;
    localparam logic [2:0] funct3Mulhsu = 3'd2;
    localparam logic [2:0] funct3Mulhu  = 3'd3;
    localparam logic [2:0] funct3Div    = 3'd4;
    localparam logic [2:0] funct3Divu   = 3'd5;
    localparam logic [2:0] funct3Rem    = 3'd6;
    localparam logic [2:0] funct3Remu   = 3'd7;

    localparam logic [2:0] funct3Priv   = 3'd0;
    localparam logic [2:0] funct3Csrrw  = 3'd1;
    localparam logic [2:0] funct3Csrrs  = 3'd2;
    localparam logic [2:0] funct3Csrrc  = 3'd3;
    localparam logic [2:0] funct3Csrrwi = 3'd5;
    localparam logic [2:0] funct3Csrrsi = 3'd6;
    localparam logic [2:0] funct3Csrrci = 3'd7;

    localparam logic [6:0] funct7Base   = 7'b0000000;
    localparam logic [6:0] funct7Alt    = 7'b0100000;
    localparam logic [6:0] funct7MulDiv = 7'b0000001;

    localparam logic [11:0] funct12Ecall  = 12'h000;
    localparam logic [11:0] funct12Ebreak = 12'h001;
    localparam logic [11:0] funct12Uret   = 12'h002;

    localparam logic [aluOpWidth-1:0] aluNull   = 5'd0;
    localparam logic [aluOpWidth-1:0] aluAdd    = 5'd1;
    localparam logic [aluOpWidth-1:0] aluSub    = 5'd2;
    localparam logic [aluOpWidth-1:0] aluSll    = 5'd3;
    localparam logic [aluOpWidth-1:0] aluSlt    = 5'd4;
    localparam logic [aluOpWidth-1:0] aluSltu   = 5'd5;
    localparam logic [aluOpWidth-1:0] aluXor    = 5'd6;
    localparam logic [aluOpWidth-1:0] aluSrl    = 5'd7;
    localparam logic [aluOpWidth-1:0] aluSra    = 5'd8;
    localparam logic [aluOpWidth-1:0] aluOr     = 5'd9;
    localparam logic [aluOpWidth-1:0] aluAnd    = 5'd10;
    localparam logic [aluOpWidth-1:0] aluLui    = 5'd11;
    localparam logic [aluOpWidth-1:0] aluMul    = 5'd12;
    localparam logic [aluOpWidth-1:0] aluMulh   = 5'd13;
    localparam logic [aluOpWidth-1:0] aluMulhsu = 5'd14;
    localparam logic [aluOpWidth-1:0] aluMulhu  = 5'd15;
    localparam logic [aluOpWidth-1:0] aluDiv    = 5'd16;
    localparam logic [aluOpWidth-1:0] aluDivu   = 5'd17;
    localparam logic [aluOpWidth-1:0] aluRem    = 5'd18;
    localparam logic [aluOpWidth-1:0] aluRemu   = 5'd19;

    localparam logic [origWidth-1:0] origAReg    = 2'b00; // Forwarded rs1
    localparam logic [origWidth-1:0] origAPc     = 2'b01;
    localparam logic [origWidth-1:0] origAImm    = 2'b10; // CSR zimm
    localparam logic [origWidth-1:0] origANotReg = 2'b11;
    localparam logic [origWidth-1:0] origBReg    = 2'b00;
    localparam logic [origWidth-1:0] origBImm    = 2'b01;
    localparam logic [origWidth-1:0] origBZero   = 2'b10;

    localparam logic [wbWidth-1:0] wbAlu     = 3'b000;
    localparam logic [wbWidth-1:0] wbPcPlus4 = 3'b001;
    localparam logic [wbWidth-1:0] wbMem     = 3'b010;
    localparam logic [wbWidth-1:0] wbCsr     = 3'b100;

    localparam logic [pcWidth-1:0] pcNext   = 3'b000;
    localparam logic [pcWidth-1:0] pcBranch = 3'b001;
    localparam logic [pcWidth-1:0] pcJal    = 3'b010;
    localparam logic [pcWidth-1:0] pcJalr   = 3'b011;
    localparam logic [pcWidth-1:0] pcEpc    = 3'b100;
    localparam logic [pcWidth-1:0] pcTvec   = 3'b101;

    localparam int typeBranch = 0;
    localparam int typeJalr   = 1;
    localparam int typeJal    = 2;
    localparam int typeI      = 3;
    localparam int typeR      = 4;
    localparam int typeStore  = 5;
    localparam int typeLoad   = 6;
    localparam int typeDivRem = 7;
    localparam int typeCsr    = 8;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrRegForm;

    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instrImmForm;

    typedef union packed {
        instrRegForm r;
        instrImmForm i;
    } instrWord;

endpackage

// File: hw/ctrlSkidBuffer.sv
`timescale 1ns/10ps

module ctrlSkidBuffer (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               inValid,
    output logic                               inReady,
    ctrlBundleIf.sink                          bundleIn,
    output logic                               outValid,
    input  logic                               outReady,
    output logic                               ecall,
    output logic                               ebreak,
    output logic                               invInstr,
    output logic [ctrlPkg::origWidth-1:0]      origA,
    output logic [ctrlPkg::origWidth-1:0]      origB,
    output logic                               regWrite,
    output logic                               csRegWrite,
    output logic                               memWrite,
    output logic                               memRead,
    output logic [ctrlPkg::wbWidth-1:0]        mem2Reg,
    output logic [ctrlPkg::pcWidth-1:0]        origPc,
    output logic [ctrlPkg::aluOpWidth-1:0]     aluControl,
    output logic [ctrlPkg::instrTypeWidth-1:0] instrType
);
    import ctrlPkg::*;

    logic [bundleWidth-1:0] inWord;
    logic [bundleWidth-1:0] headWord;
    logic [bundleWidth-1:0] skidWord;
    logic                   skidValid;
    logic                   accept;
    logic                   loadHead;

    assign inWord = {bundleIn.ecall, bundleIn.ebreak, bundleIn.invInstr, bundleIn.origA,
                     bundleIn.origB, bundleIn.regWrite, bundleIn.csRegWrite, bundleIn.memWrite,
                     bundleIn.memRead, bundleIn.mem2Reg, bundleIn.origPc, bundleIn.aluControl,
                     bundleIn.instrType};

    assign {ecall, ebreak, invInstr, origA, origB, regWrite, csRegWrite, memWrite, memRead,
            mem2Reg, origPc, aluControl, instrType} = headWord;

    assign accept   = inValid && inReady;
    assign loadHead = !outValid || outReady; // Head empty or leaving

    // inReady mirrors an empty second entry
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid  <= 1'b0;
            skidValid <= 1'b0;
            inReady   <= 1'b1;
        end else if (loadHead) begin
            outValid  <= skidValid || accept;
            skidValid <= 1'b0;
            inReady   <= 1'b1;
        end else if (accept) begin
            skidValid <= 1'b1; // Both entries full
            inReady   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadHead)
            headWord <= skidValid ? skidWord : inWord; // Older entry first
        if (!loadHead && accept)
            skidWord <= inWord;
    end

endmodule

// File: hw/systemDecoder.sv
`timescale 1ns/10ps

module systemDecoder (
    input  logic [2:0]   funct3,
    input  logic [11:0]  funct12,
    ctrlBundleIf.source  bundle
);
    import ctrlPkg::*;

    logic csrForm;
    logic csrImm;

    assign csrForm = funct3 inside {funct3Csrrw, funct3Csrrs, funct3Csrrc,
                                    funct3Csrrwi, funct3Csrrsi, funct3Csrrci};
    assign csrImm  = funct3 inside {funct3Csrrwi, funct3Csrrsi, funct3Csrrci};

    always_comb begin
        bundle.ecall      = 1'b0;
        bundle.ebreak     = 1'b0;
        bundle.invInstr   = 1'b0;
        bundle.origA      = origAReg;
        bundle.origB      = origBReg;
        bundle.regWrite   = 1'b0;
        bundle.csRegWrite = 1'b0;
        bundle.memWrite   = 1'b0;
        bundle.memRead    = 1'b0;
        bundle.mem2Reg    = wbAlu;
        bundle.origPc     = pcNext;
        bundle.aluControl = aluNull;
        bundle.instrType  = '0;

        case (funct3)
            funct3Priv: begin
                case (funct12)
                    funct12Ecall: begin
                        bundle.ecall  = 1'b1;
                        bundle.origPc = pcTvec; // Trap vector
                    end
                    funct12Ebreak: bundle.ebreak = 1'b1;
                    funct12Uret:   bundle.origPc = pcEpc;
                    default:       bundle.invInstr = 1'b1;
                endcase
            end
            funct3Csrrw, funct3Csrrwi: begin
                bundle.origB      = origBZero;
                bundle.aluControl = aluAdd;
            end
            funct3Csrrs, funct3Csrrsi: bundle.aluControl = aluOr;
            funct3Csrrc, funct3Csrrci: begin
                bundle.origA      = origANotReg; // Clear uses ~rs1
                bundle.aluControl = aluAnd;
            end
            default: bundle.invInstr = 1'b1;
        endcase

        if (csrForm) begin
            bundle.regWrite           = 1'b1;
            bundle.csRegWrite         = 1'b1;
            bundle.mem2Reg            = wbCsr;
            bundle.instrType[typeCsr] = 1'b1;
            if (csrImm)
                bundle.origA = origAImm;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the controlPipe testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/10ps --top-module controlPipeTb \
    -f controlPipe.f -o controlPipeSim > build.log 2>&1 \
    && ./obj_dir/controlPipeSim > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }

// File: tb/controlPipeInput.txt
# instr    fields: ecall ebreak invInstr origA origB regWrite csRegWrite memWrite memRead
#          mem2Reg origPc aluControl instrType, packed MSB first into 31 bits, both in hex
00012083 01940240  # lw x1, 0(x2)
00312223 01200220  # sw x3, 4(x2)
00208063 00004201  # beq x1, x2, 0
000000EF 00828004  # jal x1, 0
000100E7 0082C002  # jalr x1, 0(x2)
00001297 05800208  # auipc x5, 1
123452B7 01801608  # lui x5, 0x12345
00510093 01800208  # addi x1, x2, 5
40010093 01800208  # addi x1, x2, 0x400
FFF12093 01800808  # slti x1, x2, -1
0FF14093 01800C08  # xori x1, x2, 0xff
00717093 01801408  # andi x1, x2, 7
00315093 01800E08  # srli x1, x2, 3
40315093 01801008  # srai x1, x2, 3
003100B3 00800210  # add x1, x2, x3
403100B3 00800410  # sub x1, x2, x3
003130B3 00800A10  # sltu x1, x2, x3
003150B3 00800E10  # srl x1, x2, x3
403150B3 00801010  # sra x1, x2, x3
003160B3 00801210  # or x1, x2, x3
023100B3 00801890  # mul
023110B3 00801A90  # mulh
023120B3 00801C90  # mulhsu
023130B3 00801E90  # mulhu
023140B3 00802090  # div
023150B3 00802290  # divu
023160B3 00802490  # rem
023170B3 00802690  # remu
043100B3 10000000  # OP with undefined funct7
00000073 40014000  # ecall
00100073 20000000  # ebreak
00200073 00010000  # uret
10500073 10000000  # unknown funct12
300110F3 02C80300  # csrrw x1, 0x300, x2
300120F3 00C81300  # csrrs x1, 0x300, x2
300130F3 0CC81500  # csrrc x1, 0x300, x2
3002D0F3 0AC80300  # csrrwi x1, 0x300, 5
3002E0F3 08C81300  # csrrsi x1, 0x300, 5
3002F0F3 08C81500  # csrrci x1, 0x300, 5
300140F3 10000000  # SYSTEM with funct3 4
0000000B 10000000  # unknown opcode

// File: tb/controlPipeTb.sv
`timescale 1ns/10ps

module controlPipeTb;
    import ctrlPkg::*;

    localparam string vecPath = "tb/controlPipeInput.txt";

    logic                      clk;
    logic                      arstN;
    logic [xlen-1:0]           instr;
    logic                      instrValid;
    logic                      instrReady;
    logic                      ctrlValid;
    logic                      ctrlReady;
    logic                      ecall;
    logic                      ebreak;
    logic                      invInstr;
    logic [origWidth-1:0]      origA;
    logic [origWidth-1:0]      origB;
    logic                      regWrite;
    logic                      csRegWrite;
    logic                      memWrite;
    logic                      memRead;
    logic [wbWidth-1:0]        mem2Reg;
    logic [pcWidth-1:0]        origPc;
    logic [aluOpWidth-1:0]     aluControl;
    logic [instrTypeWidth-1:0] instrType;
    logic [bundleWidth-1:0]    observed;

    integer                    seed;
    logic [xlen-1:0]           vecInstr[$];
    logic [bundleWidth-1:0]    vecExp[$];
    logic [bundleWidth-1:0]    expQ[$]; // Accepted, not yet consumed
    logic [bundleWidth-1:0]    prevObs;
    logic                      holdPrev;
    logic                      accepting;
    int                        vecIdx;
    int                        outCount;
    int                        cycles;
    int                        cycleLimit;

    controlPipe i_dut (.*);

    assign observed = {ecall, ebreak, invInstr, origA, origB, regWrite, csRegWrite, memWrite,
                       memRead, mem2Reg, origPc, aluControl, instrType};

    always #10 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Names the highest field where two bundles differ
    function automatic string firstBadField(input logic [bundleWidth-1:0] got,
                                            input logic [bundleWidth-1:0] want);
        logic [bundleWidth-1:0] diff;
        diff = got ^ want;
        if (diff[30]) return "ecall";
        if (diff[29]) return "ebreak";
        if (diff[28]) return "invInstr";
        if (|diff[27:26]) return "origA";
        if (|diff[25:24]) return "origB";
        if (diff[23]) return "regWrite";
        if (diff[22]) return "csRegWrite";
        if (diff[21]) return "memWrite";
        if (diff[20]) return "memRead";
        if (|diff[19:17]) return "mem2Reg";
        if (|diff[16:14]) return "origPc";
        if (|diff[13:9]) return "aluControl";
        return "instrType";
    endfunction

    initial begin
        int                     fd;
        string                  line;
        logic [xlen-1:0]        word;
        logic [bundleWidth-1:0] fields;

        clk        = 1'b0;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        ctrlReady  = 1'b0;
        seed       = 46836;
        holdPrev   = 1'b0;
        accepting  = 1'b0;
        prevObs    = '0;
        vecIdx     = 0;
        outCount   = 0;
        cycles     = 0;

        fd = $fopen(vecPath, "r");
        if (fd == 0)
            failRun({"Cannot open the vector file ", vecPath});
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#"
                && $sscanf(line, "%h %h", word, fields) == 2) begin
                vecInstr.push_back(word);
                vecExp.push_back(fields);
            end
        end
        $fclose(fd);
        if (vecInstr.size() == 0)
            failRun("The vector file holds no vectors");
        cycleLimit = 8 * vecInstr.size() + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        assert (ctrlValid === 1'b0 && instrReady === 1'b1) else
            failRun($sformatf("CHECK FAILED at %0t: after reset ctrlValid %b instrReady %b",
                              $time, ctrlValid, instrReady));

        while (outCount < vecInstr.size()) begin
            if (holdPrev) begin
                assert (ctrlValid === 1'b1) else
                    failRun($sformatf("CHECK FAILED at %0t: ctrlValid dropped in a stall", $time));
                assert (observed === prevObs) else
                    failRun($sformatf("CHECK FAILED at %0t: %s changed in a stall", $time,
                                      firstBadField(observed, prevObs)));
            end
            assert (ctrlValid === (expQ.size() > 0)) else
                failRun($sformatf("CHECK FAILED at %0t: ctrlValid %b with %0d pending",
                                  $time, ctrlValid, expQ.size()));
            assert (instrReady === (expQ.size() < 2)) else // Low only with both entries full
                failRun($sformatf("CHECK FAILED at %0t: instrReady %b with %0d pending",
                                  $time, instrReady, expQ.size()));
            if (ctrlValid) begin
                assert (observed === expQ[0]) else
                    failRun($sformatf("CHECK FAILED at %0t: %s of bundle %0d, got %h expected %h",
                                      $time, firstBadField(observed, expQ[0]), outCount,
                                      observed, expQ[0]));
            end

            ctrlReady = ({$random(seed)} % 3) != 0; // Stall one cycle in three
            holdPrev  = ctrlValid && !ctrlReady;
            prevObs   = observed;
            if (ctrlValid && ctrlReady) begin
                void'(expQ.pop_front());
                outCount++;
            end

            if (accepting) begin
                instrValid = 1'b0;
                accepting  = 1'b0;
            end
            if (!instrValid && vecIdx < vecInstr.size() && ({$random(seed)} % 4) != 0) begin
                instr      = vecInstr[vecIdx];
                instrValid = 1'b1;
            end
            if (instrValid && instrReady) begin // Taken at the next rising edge
                expQ.push_back(vecExp[vecIdx]);
                vecIdx++;
                accepting = 1'b1;
            end

            @(negedge clk);
            cycles++;
            if (cycles > cycleLimit)
                failRun($sformatf("Timeout: %0d of %0d bundles came out in %0d cycles",
                                  outCount, vecInstr.size(), cycles));
        end

        ctrlReady = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (ctrlValid === 1'b0) else
                failRun($sformatf("CHECK FAILED at %0t: extra bundle after the last one", $time));
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
